//--- maze_defines.svh
`ifndef MAZE_DEFINES_SVH
`define MAZE_DEFINES_SVH

// system clocks per sclk half period
`define TFT_SPI_DIV 2

// pause after software reset and sleep out
// short for simulation, a real panel wants milliseconds
`define TFT_INIT_DELAY 64

// sprite edge in pixels
`define PLAYER_SIZE 8

// rgb565 yellow
`define PLAYER_COLOR 16'hFFE0

// start position
`define PLAYER_X0 100
`define PLAYER_Y0 101

`endif

//--- maze_pkg.sv
package maze_pkg;

    // one spi byte, command or data
    typedef logic [7:0] byte_t;

    // pixel coordinate on the 320x240 panel
    typedef logic [8:0] coord_t;

    // rgb565 pixel
    typedef logic [15:0] color_t;

    typedef enum logic [1:0] {
        SCHED_INIT,
        SCHED_DRAW,
        SCHED_IDLE
    } sched_state_t;

    typedef enum logic [1:0] {
        INIT_IDLE,
        INIT_SEND,
        INIT_WAIT,
        INIT_DONE
    } init_state_t;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_CMD,
        DRAW_PIXEL
    } draw_state_t;

endpackage

//--- tft_spi.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module tft_spi import maze_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  byte_t tx_data,
    input  logic  tx_dc,
    input  logic  tx_valid,
    output logic  tx_ready,
    output logic  tft_clk,
    output logic  tft_mosi,
    output logic  tft_dc,
    output logic  tft_cs
);

    localparam int DIV   = `TFT_SPI_DIV;
    localparam int DIV_W = $clog2(DIV + 1);

    logic             busy;
    logic             setup;
    logic             tail;
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;
    byte_t            shift_q;
    logic             accept;
    logic             half_end;
    logic             shift_en;

    assign tx_ready = !busy;
    assign accept   = tx_valid && tx_ready;

    // last cycle of an sclk half period
    assign half_end = busy && !setup && !tail && (div_cnt == DIV_W'(DIV - 1));
    // next bit goes out on the falling edge
    assign shift_en = half_end && tft_clk && (bit_cnt != 3'd7);

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= 1'b0;
            setup    <= 1'b0;
            tail     <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tft_clk  <= 1'b0;
            tft_mosi <= 1'b0;
            tft_dc   <= 1'b0;
            tft_cs   <= 1'b1;
        end else if (accept) begin
            busy     <= 1'b1;
            setup    <= 1'b1;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tft_mosi <= tx_data[7];
            tft_dc   <= tx_dc;
            tft_cs   <= 1'b0;
        end else if (busy) begin
            if (setup) begin
                setup <= 1'b0;
            end else if (tail) begin
                // cs high for one cycle, then free the shifter
                busy <= 1'b0;
                tail <= 1'b0;
            end else if (half_end) begin
                div_cnt <= '0;
                tft_clk <= !tft_clk;
                if (tft_clk && bit_cnt == 3'd7) begin
                    tft_cs <= 1'b1;
                    tail   <= 1'b1;
                end else if (shift_en) begin
                    bit_cnt  <= bit_cnt + 3'd1;
                    tft_mosi <= shift_q[6];
                end
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= tx_data;
        end else if (shift_en) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    // dc must not move inside a frame
    assert property (@(posedge clk) disable iff (!rst)
        !tft_cs |=> tft_cs || $stable(tft_dc));

    // setup, sixteen half periods, one cycle of cs high
    assert property (@(posedge clk) disable iff (!rst)
        accept |=> !tx_ready [*(16 * DIV + 2)] ##1 tx_ready);

endmodule

//--- tft_init.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module tft_init import maze_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    output byte_t tx_data,
    output logic  tx_dc,
    output logic  tx_valid,
    input  logic  tx_ready,
    output logic  done
);

    localparam int ROM_LEN = 7;
    localparam int IDX_W   = $clog2(ROM_LEN);
    localparam int DELAY   = `TFT_INIT_DELAY;
    localparam int DELAY_W = $clog2(DELAY + 1);

    init_state_t        state;
    logic [IDX_W-1:0]   idx;
    logic [DELAY_W-1:0] wait_cnt;
    logic               entry_wait;
    logic               last;
    logic               accept;

    // power-up list: byte, dc, pause after
    always_comb begin
        case (idx)
            IDX_W'(0): {tx_data, tx_dc, entry_wait} = {8'h01, 1'b0, 1'b1};
            IDX_W'(1): {tx_data, tx_dc, entry_wait} = {8'h11, 1'b0, 1'b1};
            // 16 bit pixels
            IDX_W'(2): {tx_data, tx_dc, entry_wait} = {8'h3A, 1'b0, 1'b0};
            IDX_W'(3): {tx_data, tx_dc, entry_wait} = {8'h55, 1'b1, 1'b0};
            // madctl, bgr order
            IDX_W'(4): {tx_data, tx_dc, entry_wait} = {8'h36, 1'b0, 1'b0};
            IDX_W'(5): {tx_data, tx_dc, entry_wait} = {8'h48, 1'b1, 1'b0};
            IDX_W'(6): {tx_data, tx_dc, entry_wait} = {8'h29, 1'b0, 1'b0};
            default:   {tx_data, tx_dc, entry_wait} = {8'h00, 1'b0, 1'b0};
        endcase
    end

    assign tx_valid = (state == INIT_SEND);
    assign accept   = tx_valid && tx_ready;
    assign last     = (idx == IDX_W'(ROM_LEN - 1));
    assign done     = accept && last;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= INIT_IDLE;
            idx      <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                INIT_IDLE, INIT_DONE: begin
                    if (start) begin
                        state <= INIT_SEND;
                        idx   <= '0;
                    end
                end
                INIT_SEND: begin
                    if (accept) begin
                        if (last) begin
                            state <= INIT_DONE;
                        end else if (entry_wait) begin
                            state    <= INIT_WAIT;
                            wait_cnt <= '0;
                        end else begin
                            idx <= idx + IDX_W'(1);
                        end
                    end
                end
                INIT_WAIT: begin
                    if (wait_cnt == DELAY_W'(DELAY - 1)) begin
                        state <= INIT_SEND;
                        idx   <= idx + IDX_W'(1);
                    end else begin
                        wait_cnt <= wait_cnt + DELAY_W'(1);
                    end
                end
                default: state <= INIT_IDLE;
            endcase
        end
    end

    // panel gets its full pause after reset and sleep out
    assert property (@(posedge clk) disable iff (!rst)
        accept && entry_wait && !last |=> !tx_valid [*DELAY]);

endmodule

//--- player_draw.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module player_draw import maze_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  coord_t x,
    input  coord_t y,
    output byte_t  tx_data,
    output logic   tx_dc,
    output logic   tx_valid,
    input  logic   tx_ready,
    output logic   done
);

    localparam int     SIZE      = `PLAYER_SIZE;
    localparam int     PIX_BYTES = 2 * SIZE * SIZE;
    localparam int     PIX_W     = $clog2(PIX_BYTES);
    localparam int     CMD_LEN   = 11;
    localparam color_t COLOR     = `PLAYER_COLOR;

    draw_state_t      state;
    coord_t           x_q;
    coord_t           y_q;
    logic [3:0]       cmd_idx;
    logic [PIX_W-1:0] pix_cnt;
    logic [15:0]      x_first;
    logic [15:0]      x_last;
    logic [15:0]      y_first;
    logic [15:0]      y_last;
    logic             accept;

    // window corners as 16 bit panel addresses
    assign x_first = 16'(x_q);
    assign x_last  = 16'(x_q) + 16'(SIZE - 1);
    assign y_first = 16'(y_q);
    assign y_last  = 16'(y_q) + 16'(SIZE - 1);

    assign tx_valid = (state != DRAW_IDLE);
    assign accept   = tx_valid && tx_ready;
    assign done     = accept && (state == DRAW_PIXEL) && (pix_cnt == PIX_W'(PIX_BYTES - 1));

    always_comb begin
        tx_data = 8'h00;
        tx_dc   = 1'b1;
        if (state == DRAW_PIXEL) begin
            // high byte first
            tx_data = pix_cnt[0] ? COLOR[7:0] : COLOR[15:8];
        end else begin
            case (cmd_idx)
                4'd0: begin
                    tx_data = 8'h2A;
                    tx_dc   = 1'b0;
                end
                4'd1: tx_data = x_first[15:8];
                4'd2: tx_data = x_first[7:0];
                4'd3: tx_data = x_last[15:8];
                4'd4: tx_data = x_last[7:0];
                4'd5: begin
                    tx_data = 8'h2B;
                    tx_dc   = 1'b0;
                end
                4'd6: tx_data = y_first[15:8];
                4'd7: tx_data = y_first[7:0];
                4'd8: tx_data = y_last[15:8];
                4'd9: tx_data = y_last[7:0];
                4'd10: begin
                    tx_data = 8'h2C;
                    tx_dc   = 1'b0;
                end
                default: tx_data = 8'h00;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= DRAW_IDLE;
            cmd_idx <= '0;
            pix_cnt <= '0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    if (start) begin
                        state   <= DRAW_CMD;
                        cmd_idx <= '0;
                    end
                end
                DRAW_CMD: begin
                    if (accept) begin
                        if (cmd_idx == 4'(CMD_LEN - 1)) begin
                            state   <= DRAW_PIXEL;
                            pix_cnt <= '0;
                        end else begin
                            cmd_idx <= cmd_idx + 4'd1;
                        end
                    end
                end
                DRAW_PIXEL: begin
                    if (accept) begin
                        if (done) begin
                            state <= DRAW_IDLE;
                        end else begin
                            pix_cnt <= pix_cnt + PIX_W'(1);
                        end
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == DRAW_IDLE) begin
            x_q <= x;
            y_q <= y;
        end
    end

    // byte and flag held while the transmitter is busy
    assert property (@(posedge clk) disable iff (!rst)
        tx_valid && !tx_ready |=> $stable(tx_data) && $stable(tx_dc));

endmodule

//--- tft_scheduler.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module tft_scheduler import maze_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    output logic   init_start,
    input  logic   init_done_pulse,
    input  byte_t  init_data,
    input  logic   init_dc,
    input  logic   init_valid,
    output logic   init_ready,
    output logic   draw_start,
    input  logic   draw_done,
    output coord_t draw_x,
    output coord_t draw_y,
    input  byte_t  draw_data,
    input  logic   draw_dc,
    input  logic   draw_valid,
    output logic   draw_ready,
    output byte_t  tx_data,
    output logic   tx_dc,
    output logic   tx_valid,
    input  logic   tx_ready,
    input  coord_t pos_x,
    input  coord_t pos_y,
    input  logic   pos_valid,
    output logic   pos_ready,
    output logic   init_done
);

    sched_state_t state;
    logic         in_init;
    logic         in_draw;
    logic         pos_accept;

    assign in_init    = (state == SCHED_INIT);
    assign in_draw    = (state == SCHED_DRAW);
    assign pos_ready  = (state == SCHED_IDLE);
    assign pos_accept = pos_valid && pos_ready;

    // byte link goes to whichever source owns the state
    assign tx_data    = in_draw ? draw_data : init_data;
    assign tx_dc      = in_draw ? draw_dc : init_dc;
    assign tx_valid   = (in_init && init_valid) || (in_draw && draw_valid);
    assign init_ready = in_init && tx_ready;
    assign draw_ready = in_draw && tx_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= SCHED_INIT;
            // fires on the first cycle out of reset
            init_start <= 1'b1;
            draw_start <= 1'b0;
            init_done  <= 1'b0;
        end else begin
            init_start <= 1'b0;
            draw_start <= 1'b0;
            case (state)
                SCHED_INIT: begin
                    if (init_done_pulse) begin
                        state      <= SCHED_DRAW;
                        draw_start <= 1'b1;
                        init_done  <= 1'b1;
                    end
                end
                SCHED_DRAW: begin
                    if (draw_done) begin
                        state <= SCHED_IDLE;
                    end
                end
                SCHED_IDLE: begin
                    if (pos_valid) begin
                        state      <= SCHED_DRAW;
                        draw_start <= 1'b1;
                    end
                end
                default: state <= SCHED_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_init && init_done_pulse) begin
            draw_x <= coord_t'(`PLAYER_X0);
            draw_y <= coord_t'(`PLAYER_Y0);
        end else if (pos_accept) begin
            draw_x <= pos_x;
            draw_y <= pos_y;
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        !(init_start && draw_start));

endmodule

//--- maze_top.sv
`timescale 1ns/1ns

module maze_top import maze_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  coord_t pos_x,
    input  coord_t pos_y,
    input  logic   pos_valid,
    output logic   pos_ready,
    output logic   init_done,
    output logic   led_busy,
    output logic   tft_rst,
    output logic   tft_clk,
    output logic   tft_mosi,
    output logic   tft_dc,
    output logic   tft_cs
);

    logic   init_start;
    logic   init_done_pulse;
    byte_t  init_data;
    logic   init_dc;
    logic   init_valid;
    logic   init_ready;
    logic   draw_start;
    logic   draw_done;
    coord_t draw_x;
    coord_t draw_y;
    byte_t  draw_data;
    logic   draw_dc;
    logic   draw_valid;
    logic   draw_ready;
    byte_t  tx_data;
    logic   tx_dc;
    logic   tx_valid;
    logic   tx_ready;

    // panel reset follows the board reset
    assign tft_rst  = rst;
    assign led_busy = !pos_ready;

    tft_scheduler scheduler_i (
        .clk,
        .rst,
        .init_start,
        .init_done_pulse,
        .init_data,
        .init_dc,
        .init_valid,
        .init_ready,
        .draw_start,
        .draw_done,
        .draw_x,
        .draw_y,
        .draw_data,
        .draw_dc,
        .draw_valid,
        .draw_ready,
        .tx_data,
        .tx_dc,
        .tx_valid,
        .tx_ready,
        .pos_x,
        .pos_y,
        .pos_valid,
        .pos_ready,
        .init_done
    );

    tft_init init_i (
        .clk      (clk),
        .rst      (rst),
        .start    (init_start),
        .tx_data  (init_data),
        .tx_dc    (init_dc),
        .tx_valid (init_valid),
        .tx_ready (init_ready),
        .done     (init_done_pulse)
    );

    player_draw draw_i (
        .clk      (clk),
        .rst      (rst),
        .start    (draw_start),
        .x        (draw_x),
        .y        (draw_y),
        .tx_data  (draw_data),
        .tx_dc    (draw_dc),
        .tx_valid (draw_valid),
        .tx_ready (draw_ready),
        .done     (draw_done)
    );

    tft_spi spi_i (
        .clk,
        .rst,
        .tx_data,
        .tx_dc,
        .tx_valid,
        .tx_ready,
        .tft_clk,
        .tft_mosi,
        .tft_dc,
        .tft_cs
    );

endmodule

//--- tb_tft_model.sv
`timescale 1ns/1ns

module tb_tft_model (
    input  logic       clk,
    input  logic       rst,
    input  logic       tft_clk,
    input  logic       tft_mosi,
    input  logic       tft_dc,
    input  logic       tft_cs,
    output logic       rx_valid,
    output logic [8:0] rx_word,
    output logic       bus_error
);

    logic       clk_q;
    logic       cs_q;
    logic       dc_q;
    logic [3:0] edge_cnt;
    logic [7:0] shift_q;

    initial bus_error = 1'b0;

    // panel side receiver, samples mosi on rising sclk
    always_ff @(posedge clk) begin
        if (!rst) begin
            clk_q    <= 1'b0;
            cs_q     <= 1'b1;
            dc_q     <= 1'b0;
            edge_cnt <= '0;
            shift_q  <= '0;
            rx_valid <= 1'b0;
            rx_word  <= '0;
        end else begin
            clk_q    <= tft_clk;
            cs_q     <= tft_cs;
            rx_valid <= 1'b0;
            if (tft_cs) begin
                edge_cnt <= '0;
                // end of frame
                if (!cs_q) begin
                    rx_valid <= 1'b1;
                    rx_word  <= {dc_q, shift_q};
                end
            end else if (tft_clk && !clk_q) begin
                shift_q  <= {shift_q[6:0], tft_mosi};
                edge_cnt <= edge_cnt + 4'd1;
                dc_q     <= tft_dc;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst)
        tft_cs |-> !tft_clk)
    else begin
        $display("sclk was high while cs was high");
        bus_error = 1'b1;
    end

    assert property (@(posedge clk) disable iff (!rst)
        !tft_cs |=> tft_cs || $stable(tft_dc))
    else begin
        $display("dc changed in the middle of a frame");
        bus_error = 1'b1;
    end

    // one byte per frame
    assert property (@(posedge clk) disable iff (!rst)
        tft_cs && !cs_q |-> edge_cnt == 4'd8)
    else begin
        $display("a frame did not carry exactly eight sclk pulses");
        bus_error = 1'b1;
    end

endmodule

//--- tb_maze.sv
`timescale 1ns/1ns
`include "maze_defines.svh"

module tb_maze import maze_pkg::*; ();

    localparam int BYTE_TIMEOUT = 500;
    localparam int POS_TIMEOUT  = 10000;
    localparam int QUIET_CYCLES = 200;

    logic       clk;
    logic       rst;
    coord_t     pos_x;
    coord_t     pos_y;
    logic       pos_valid;
    logic       pos_ready;
    logic       init_done;
    logic       led_busy;
    logic       tft_rst;
    logic       tft_clk;
    logic       tft_mosi;
    logic       tft_dc;
    logic       tft_cs;
    logic       rx_valid;
    logic [8:0] rx_word;
    logic       bus_error;
    logic [8:0] rx_q[$];
    logic [8:0] exp_q[$];
    logic [31:0] lcg_state;
    coord_t     held_x;
    coord_t     held_y;

    maze_top maze_top_i (
        .clk       (clk),
        .rst       (rst),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .pos_valid (pos_valid),
        .pos_ready (pos_ready),
        .init_done (init_done),
        .led_busy  (led_busy),
        .tft_rst   (tft_rst),
        .tft_clk   (tft_clk),
        .tft_mosi  (tft_mosi),
        .tft_dc    (tft_dc),
        .tft_cs    (tft_cs)
    );

    tb_tft_model model_i (
        .clk       (clk),
        .rst       (rst),
        .tft_clk   (tft_clk),
        .tft_mosi  (tft_mosi),
        .tft_dc    (tft_dc),
        .tft_cs    (tft_cs),
        .rx_valid  (rx_valid),
        .rx_word   (rx_word),
        .bus_error (bus_error)
    );

    initial clk = 1'b0;
    always #2 clk = !clk;

    always @(posedge clk) begin
        if (rx_valid) begin
            rx_q.push_back(rx_word);
        end
    end

    always @(posedge clk) begin
        if (bus_error) begin
            fail_now("display model reported a broken SPI frame");
        end
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic value_error(input string test, input logic [31:0] want,
                               input logic [31:0] got);
        fail_now($sformatf("Error %s: expected %0h, actual %0h", test, want, got));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic void add_init_expected();
        exp_q.push_back({1'b0, 8'h01});
        exp_q.push_back({1'b0, 8'h11});
        exp_q.push_back({1'b0, 8'h3A});
        exp_q.push_back({1'b1, 8'h55});
        exp_q.push_back({1'b0, 8'h36});
        exp_q.push_back({1'b1, 8'h48});
        exp_q.push_back({1'b0, 8'h29});
    endfunction

    // window for an 8x8 square, then the pixels high byte first
    function automatic void add_draw_expected(input int x, input int y);
        int x_end;
        int y_end;
        x_end = x + `PLAYER_SIZE - 1;
        y_end = y + `PLAYER_SIZE - 1;
        exp_q.push_back({1'b0, 8'h2A});
        exp_q.push_back({1'b1, 8'(x >> 8)});
        exp_q.push_back({1'b1, 8'(x)});
        exp_q.push_back({1'b1, 8'(x_end >> 8)});
        exp_q.push_back({1'b1, 8'(x_end)});
        exp_q.push_back({1'b0, 8'h2B});
        exp_q.push_back({1'b1, 8'(y >> 8)});
        exp_q.push_back({1'b1, 8'(y)});
        exp_q.push_back({1'b1, 8'(y_end >> 8)});
        exp_q.push_back({1'b1, 8'(y_end)});
        exp_q.push_back({1'b0, 8'h2C});
        for (int i = 0; i < `PLAYER_SIZE * `PLAYER_SIZE; i++) begin
            exp_q.push_back({1'b1, 8'(`PLAYER_COLOR >> 8)});
            exp_q.push_back({1'b1, 8'(`PLAYER_COLOR)});
        end
    endfunction

    task automatic check_idle_pins(input string test);
        assert (tft_cs == 1'b1) else value_error({test, " tft_cs"}, 1, tft_cs);
        assert (tft_clk == 1'b0) else value_error({test, " tft_clk"}, 0, tft_clk);
        assert (pos_ready == 1'b0) else value_error({test, " pos_ready"}, 0, pos_ready);
        assert (init_done == 1'b0) else value_error({test, " init_done"}, 0, init_done);
        assert (led_busy == 1'b1) else value_error({test, " led_busy"}, 1, led_busy);
    endtask

    // hold_ready also checks pos_ready stays low until the last byte is due
    task automatic check_stream(input string test, input bit hold_ready);
        logic [8:0] want;
        logic [8:0] got;
        int         waited;
        int         taken;
        int         total;
        total = exp_q.size();
        taken = 0;
        while (exp_q.size() > 0) begin
            waited = 0;
            while (rx_q.size() == 0) begin
                if (hold_ready && taken < total - 1) begin
                    assert (!pos_ready)
                    else fail_now($sformatf("%s: pos_ready rose before the redraw ended", test));
                end
                if (waited == BYTE_TIMEOUT) begin
                    fail_now($sformatf("%s: no byte arrived for entry %0d", test, taken));
                end
                @(posedge clk);
                #1;
                waited++;
            end
            want = exp_q.pop_front();
            got  = rx_q.pop_front();
            assert (got == want)
            else value_error($sformatf("%s entry %0d", test, taken), want, got);
            taken++;
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic offer_position(input coord_t x, input coord_t y);
        int waited;
        pos_x     = x;
        pos_y     = y;
        pos_valid = 1'b1;
        waited    = 0;
        while (!pos_ready) begin
            if (waited == POS_TIMEOUT) begin
                fail_now("a position was offered but never accepted");
            end
            @(posedge clk);
            #1;
            waited++;
        end
        @(posedge clk);
        #1;
        pos_valid = 1'b0;
    endtask

    task automatic random_position(output coord_t x, output coord_t y);
        x = coord_t'((lcg_next() >> 8) % 313);
        y = coord_t'((lcg_next() >> 8) % 233);
    endtask

    initial begin
        coord_t qx;
        coord_t qy;
        rst       = 1'b0;
        pos_x     = '0;
        pos_y     = '0;
        pos_valid = 1'b0;
        lcg_state = 32'd53440;

        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            #1;
            check_idle_pins("reset");
            assert (tft_rst == 1'b0) else value_error("reset tft_rst", 0, tft_rst);
        end
        rst = 1'b1;
        @(posedge clk);
        #1;
        check_idle_pins("after reset");
        assert (tft_rst == 1'b1) else value_error("after reset tft_rst", 1, tft_rst);

        add_init_expected();
        check_stream("init", 1'b0);
        assert (init_done) else value_error("init done", 1, init_done);

        add_draw_expected(`PLAYER_X0, `PLAYER_Y0);
        check_stream("start draw", 1'b0);
        assert (pos_ready) else value_error("start draw pos_ready", 1, pos_ready);
        assert (!led_busy) else value_error("start draw led_busy", 0, led_busy);

        for (int k = 0; k < 3; k++) begin
            random_position(qx, qy);
            add_draw_expected(qx, qy);
            offer_position(qx, qy);
            check_stream($sformatf("random draw %0d", k), 1'b0);
            assert (pos_ready) else value_error("random draw pos_ready", 1, pos_ready);
        end

        // second position waits on pos_valid through the whole first redraw
        random_position(qx, qy);
        random_position(held_x, held_y);
        add_draw_expected(qx, qy);
        offer_position(qx, qy);
        fork
            check_stream("busy redraw", 1'b1);
            begin
                @(posedge clk);
                #1;
                offer_position(held_x, held_y);
            end
        join
        add_draw_expected(held_x, held_y);
        check_stream("held position", 1'b0);

        repeat (QUIET_CYCLES) begin
            @(posedge clk);
        end
        #1;
        assert (rx_q.size() == 0) else value_error("held position repeat", 0, rx_q.size());
        assert (pos_ready) else value_error("held position pos_ready", 1, pos_ready);
        assert (!led_busy) else value_error("held position led_busy", 0, led_busy);
        assert (init_done) else value_error("final init_done", 1, init_done);

        $display("Test passed");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
maze_pkg.sv
tft_spi.sv
tft_init.sv
player_draw.sv
tft_scheduler.sv
maze_top.sv
tb_tft_model.sv
tb_maze.sv

//--- Bender.yml
package:
  name: maze_tft

sources:
  # synthesizable design
  - target: rtl
    include_dirs:
      - .
    files:
      - maze_pkg.sv
      - tft_spi.sv
      - tft_init.sv
      - player_draw.sv
      - tft_scheduler.sv
      - maze_top.sv

  # simulation only
  - target: test
    include_dirs:
      - .
    files:
      - tb_tft_model.sv
      - tb_maze.sv
